/* run_sim.sh */
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_uart -f uart_sys.f \
  --Mdir obj_dir -o sim_tb_uart \
  && ./obj_dir/sim_tb_uart | tee /dev/stderr | grep -x "Test passed" > /dev/null \
  && echo "Simulation run: PASS" \
  || { echo "Simulation run: FAIL"; exit 1; }

/* src/uart.sv */
// UART top level joining the register block, transmitter and receiver
`timescale 1ns/1ps

module uart #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_i,
  // Register bus
  input  logic        req_i,
  input  logic        we_i,
  input  logic [7:0]  addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  // Serial pins
  input  logic        rx_i,
  output logic        tx_o,
  output logic        tx_en_o,
  // Level interrupts
  output logic        intr_tx_empty_o,
  output logic        intr_rx_overflow_o,
  output logic        intr_rx_frame_err_o,
  output logic        intr_rx_parity_err_o
);

  logic                       tx_valid;
  logic [7:0]                 tx_data;
  logic                       tx_pop;
  logic                       tx_idle;
  logic                       rx_valid;
  uart_pkg::rx_entry_t        rx_entry;
  logic [uart_pkg::DIV_W-1:0] div;
  logic                       parity_en;
  logic                       rx_en;

  uart_regs #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_regs (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .req_i                (req_i),
    .we_i                 (we_i),
    .addr_i               (addr_i),
    .wdata_i              (wdata_i),
    .rdata_o              (rdata_o),
    .tx_valid_o           (tx_valid),
    .tx_data_o            (tx_data),
    .tx_pop_i             (tx_pop),
    .tx_idle_i            (tx_idle),
    .rx_valid_i           (rx_valid),
    .rx_entry_i           (rx_entry),
    .div_o                (div),
    .parity_en_o          (parity_en),
    .rx_en_o              (rx_en),
    .intr_tx_empty_o      (intr_tx_empty_o),
    .intr_rx_overflow_o   (intr_rx_overflow_o),
    .intr_rx_frame_err_o  (intr_rx_frame_err_o),
    .intr_rx_parity_err_o (intr_rx_parity_err_o)
  );

  uart_tx u_tx (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (tx_valid),
    .data_i      (tx_data),
    .pop_o       (tx_pop),
    .div_i       (div),
    .parity_en_i (parity_en),
    .tx_o        (tx_o),
    .idle_o      (tx_idle)
  );

  uart_rx u_rx (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .en_i        (rx_en),
    .rx_i        (rx_i),
    .div_i       (div),
    .parity_en_i (parity_en),
    .valid_o     (rx_valid),
    .entry_o     (rx_entry)
  );

  // Transmit pin always driven
  assign tx_en_o = 1'b1;

endmodule

/* src/uart_fifo.sv */
// Synchronous circular FIFO with a type parameter payload
`timescale 1ns/1ps

module uart_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap explicitly so any depth works
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);

  // Push on full and pop on empty are ignored
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head shown without a register stage
  assign data_o = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

/* src/uart_pkg.sv */
// UART register map, field positions, receive entry type and divisor width
package uart_pkg;

  // Register window addresses
  localparam logic [7:0] ADDR_CTRL        = 8'h00;
  localparam logic [7:0] ADDR_STATUS      = 8'h04;
  localparam logic [7:0] ADDR_WDATA       = 8'h08;
  localparam logic [7:0] ADDR_RDATA       = 8'h0C;
  localparam logic [7:0] ADDR_INTR_STATE  = 8'h10;
  localparam logic [7:0] ADDR_INTR_ENABLE = 8'h14;

  // CTRL fields
  localparam int CTRL_TX_EN     = 0;
  localparam int CTRL_RX_EN     = 1;
  localparam int CTRL_PARITY_EN = 2;
  localparam int CTRL_DIV_LSB   = 16;

  // Baud divisor in clocks per bit
  localparam int DIV_W   = 16;
  localparam int DIV_MIN = 4;

  // STATUS fields
  localparam int STATUS_TX_FULL  = 0;
  localparam int STATUS_TX_EMPTY = 1;
  localparam int STATUS_RX_FULL  = 2;
  localparam int STATUS_RX_EMPTY = 3;
  localparam int STATUS_TX_IDLE  = 4;

  // Interrupt positions for state and enable
  localparam int NUM_INTR           = 4;
  localparam int INTR_TX_EMPTY      = 0;
  localparam int INTR_RX_OVERFLOW   = 1;
  localparam int INTR_RX_FRAME_ERR  = 2;
  localparam int INTR_RX_PARITY_ERR = 3;

  // Receive FIFO entry with parity error on top
  typedef struct packed {
    logic       parity_err;
    logic       frame_err;
    logic [7:0] data;
  } rx_entry_t;

endpackage

/* src/uart_regs.sv */
// UART register block with CTRL, STATUS, data windows, interrupts and both FIFOs
`timescale 1ns/1ps

module uart_regs #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [7:0]                 addr_i,
  input  logic [31:0]                wdata_i,
  output logic [31:0]                rdata_o,
  output logic                       tx_valid_o,
  output logic [7:0]                 tx_data_o,
  input  logic                       tx_pop_i,
  input  logic                       tx_idle_i,
  input  logic                       rx_valid_i,
  input  uart_pkg::rx_entry_t        rx_entry_i,
  output logic [uart_pkg::DIV_W-1:0] div_o,
  output logic                       parity_en_o,
  output logic                       rx_en_o,
  output logic                       intr_tx_empty_o,
  output logic                       intr_rx_overflow_o,
  output logic                       intr_rx_frame_err_o,
  output logic                       intr_rx_parity_err_o
);

  logic                          wr;
  logic                          rd;
  logic                          tx_en_q;
  logic [uart_pkg::DIV_W-1:0]    div_q;
  logic                          tx_full;
  logic                          tx_empty;
  logic                          tx_empty_q;
  logic                          rx_full;
  logic                          rx_empty;
  logic                          rx_pop;
  uart_pkg::rx_entry_t           rx_head;
  logic [uart_pkg::NUM_INTR-1:0] intr_state;
  logic [uart_pkg::NUM_INTR-1:0] intr_enable;
  logic [uart_pkg::NUM_INTR-1:0] intr_event;
  logic [uart_pkg::NUM_INTR-1:0] intr_q;
  logic [31:0]                   ctrl_rd;
  logic [31:0]                   status_rd;

  assign wr     = req_i && we_i;
  assign rd     = req_i && !we_i;
  assign rx_pop = rd && (addr_i == uart_pkg::ADDR_RDATA);

  uart_fifo #(
    .T     (logic [7:0]),
    .DEPTH (FIFO_DEPTH)
  ) u_tx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (wr && (addr_i == uart_pkg::ADDR_WDATA)),
    .data_i  (wdata_i[7:0]),
    .pop_i   (tx_pop_i),
    .data_o  (tx_data_o),
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  // Entry dropped by the FIFO itself when full
  uart_fifo #(
    .T     (uart_pkg::rx_entry_t),
    .DEPTH (FIFO_DEPTH)
  ) u_rx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rx_valid_i),
    .data_i  (rx_entry_i),
    .pop_i   (rx_pop),
    .data_o  (rx_head),
    .full_o  (rx_full),
    .empty_o (rx_empty)
  );

  assign tx_valid_o = !tx_empty && tx_en_q;

  // Divisor floor of DIV_MIN clocks per bit
  assign div_o = (div_q < uart_pkg::DIV_W'(uart_pkg::DIV_MIN)) ?
                 uart_pkg::DIV_W'(uart_pkg::DIV_MIN) : div_q;

  // CTRL readback
  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[uart_pkg::CTRL_TX_EN]     = tx_en_q;
    ctrl_rd[uart_pkg::CTRL_RX_EN]     = rx_en_o;
    ctrl_rd[uart_pkg::CTRL_PARITY_EN] = parity_en_o;
    ctrl_rd[uart_pkg::CTRL_DIV_LSB +: uart_pkg::DIV_W] = div_q;
  end

  always_comb begin
    status_rd = '0;
    status_rd[uart_pkg::STATUS_TX_FULL]  = tx_full;
    status_rd[uart_pkg::STATUS_TX_EMPTY] = tx_empty;
    status_rd[uart_pkg::STATUS_RX_FULL]  = rx_full;
    status_rd[uart_pkg::STATUS_RX_EMPTY] = rx_empty;
    status_rd[uart_pkg::STATUS_TX_IDLE]  = tx_idle_i;
  end

  // Error flags only count on a real push
  always_comb begin
    intr_event = '0;
    intr_event[uart_pkg::INTR_TX_EMPTY]      = tx_empty && !tx_empty_q;
    intr_event[uart_pkg::INTR_RX_OVERFLOW]   = rx_valid_i && rx_full;
    intr_event[uart_pkg::INTR_RX_FRAME_ERR]  = rx_valid_i && !rx_full && rx_entry_i.frame_err;
    intr_event[uart_pkg::INTR_RX_PARITY_ERR] = rx_valid_i && !rx_full && rx_entry_i.parity_err;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_en_q     <= 1'b0;
      rx_en_o     <= 1'b0;
      parity_en_o <= 1'b0;
      div_q       <= '0;
      intr_enable <= '0;
      intr_state  <= '0;
      tx_empty_q  <= 1'b1;
      intr_q      <= '0;
      rdata_o     <= '0;
    end else begin
      tx_empty_q <= tx_empty;
      intr_q     <= intr_state & intr_enable;
      if (wr && addr_i == uart_pkg::ADDR_CTRL) begin
        tx_en_q     <= wdata_i[uart_pkg::CTRL_TX_EN];
        rx_en_o     <= wdata_i[uart_pkg::CTRL_RX_EN];
        parity_en_o <= wdata_i[uart_pkg::CTRL_PARITY_EN];
        div_q       <= wdata_i[uart_pkg::CTRL_DIV_LSB +: uart_pkg::DIV_W];
      end
      if (wr && addr_i == uart_pkg::ADDR_INTR_ENABLE) begin
        intr_enable <= wdata_i[uart_pkg::NUM_INTR-1:0];
      end
      // New events win over a write-1 clear in the same cycle
      if (wr && addr_i == uart_pkg::ADDR_INTR_STATE) begin
        intr_state <= (intr_state & ~wdata_i[uart_pkg::NUM_INTR-1:0]) | intr_event;
      end else begin
        intr_state <= intr_state | intr_event;
      end
      if (rd) begin
        case (addr_i)
          uart_pkg::ADDR_CTRL:        rdata_o <= ctrl_rd;
          uart_pkg::ADDR_STATUS:      rdata_o <= status_rd;
          uart_pkg::ADDR_RDATA:       rdata_o <= rx_empty ? '0 : {22'd0, rx_head};
          uart_pkg::ADDR_INTR_STATE:  rdata_o <= {28'd0, intr_state};
          uart_pkg::ADDR_INTR_ENABLE: rdata_o <= {28'd0, intr_enable};
          default:                    rdata_o <= '0;
        endcase
      end
    end
  end

  assign intr_tx_empty_o      = intr_q[uart_pkg::INTR_TX_EMPTY];
  assign intr_rx_overflow_o   = intr_q[uart_pkg::INTR_RX_OVERFLOW];
  assign intr_rx_frame_err_o  = intr_q[uart_pkg::INTR_RX_FRAME_ERR];
  assign intr_rx_parity_err_o = intr_q[uart_pkg::INTR_RX_PARITY_ERR];

endmodule

/* src/uart_rx.sv */
// UART receive sampler with start detect, mid-bit sampling and error checks
`timescale 1ns/1ps

module uart_rx (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       en_i,
  input  logic                       rx_i,
  input  logic [uart_pkg::DIV_W-1:0] div_i,
  input  logic                       parity_en_i,
  output logic                       valid_o,
  output uart_pkg::rx_entry_t        entry_o
);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

  rx_state_e                  state;
  logic [uart_pkg::DIV_W-1:0] cnt;
  logic [2:0]                 bit_cnt;
  logic                       rx_meta;
  logic                       rx_sync;
  logic                       rx_last;
  logic [7:0]                 shreg;
  logic                       par_q;
  logic                       tick;

  // Mid-bit sample point reached
  assign tick = (cnt == '0);

  // Two flop synchronizer plus edge history with the line idling high
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      case (state)
        RX_IDLE: begin
          // Falling edge marks the start bit
          if (en_i && rx_last && !rx_sync) begin
            state <= RX_START;
            cnt   <= (div_i >> 1) - 1'b1;
          end
        end
        RX_START: begin
          if (!tick) begin
            cnt <= cnt - 1'b1;
          end else if (rx_sync) begin
            // High at mid start bit means a glitch
            state <= RX_IDLE;
          end else begin
            state   <= RX_DATA;
            cnt     <= div_i - 1'b1;
            bit_cnt <= '0;
          end
        end
        RX_DATA: begin
          if (!tick) begin
            cnt <= cnt - 1'b1;
          end else begin
            cnt     <= div_i - 1'b1;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= parity_en_i ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: begin
          if (!tick) begin
            cnt <= cnt - 1'b1;
          end else begin
            cnt   <= div_i - 1'b1;
            state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (!tick) begin
            cnt <= cnt - 1'b1;
          end else begin
            valid_o <= 1'b1;
            state   <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Payload capture at each sample point
  always_ff @(posedge clk_i) begin
    if (tick && state == RX_DATA) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
    if (tick && state == RX_PARITY) begin
      par_q <= rx_sync;
    end
    if (tick && state == RX_STOP) begin
      entry_o.data       <= shreg;
      entry_o.frame_err  <= !rx_sync;
      // Even parity over data and parity bit
      entry_o.parity_err <= parity_en_i && (^{shreg, par_q});
    end
  end

endmodule

/* src/uart_tx.sv */
// UART transmit shifter with baud counter, even parity and idle flag
`timescale 1ns/1ps

module uart_tx (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [7:0]                 data_i,
  output logic                       pop_o,
  input  logic [uart_pkg::DIV_W-1:0] div_i,
  input  logic                       parity_en_i,
  output logic                       tx_o,
  output logic                       idle_o
);

  logic                       busy;
  logic [uart_pkg::DIV_W-1:0] cnt;
  logic [3:0]                 bits_left;
  logic [9:0]                 shreg;
  logic                       bit_end;
  logic                       frame_done;

  assign bit_end    = busy && (cnt == '0);
  // Stop bit has run its full bit time
  assign frame_done = bit_end && (bits_left == '0);

  // Next byte may be taken as the stop bit ends so frames run back to back
  assign pop_o  = valid_i && (!busy || frame_done);
  assign idle_o = !busy;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy      <= 1'b0;
      tx_o      <= 1'b1;
      cnt       <= '0;
      bits_left <= '0;
    end else if (pop_o) begin
      // Start bit goes out one cycle after the pop
      busy      <= 1'b1;
      tx_o      <= 1'b0;
      cnt       <= div_i - 1'b1;
      bits_left <= parity_en_i ? 4'd10 : 4'd9;
    end else if (frame_done) begin
      busy <= 1'b0;
    end else if (bit_end) begin
      tx_o      <= shreg[0];
      bits_left <= bits_left - 1'b1;
      cnt       <= div_i - 1'b1;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Data LSB first, then parity if enabled, then stop
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      if (parity_en_i) begin
        shreg <= {1'b1, ^data_i, data_i};
      end else begin
        shreg <= {2'b11, data_i};
      end
    end else if (bit_end && bits_left != '0) begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

endmodule

/* test/tb_uart.sv */
// Testbench for the UART: register bus driver, serial injector, stimulus table and checks
`timescale 1ns/1ps

module tb_uart;

  localparam int FIFO_DEPTH  = 4;
  localparam int NUM_ENTRIES = 12;
  localparam int MAX_DIV     = 7;
  localparam int CYCLE_LIMIT = NUM_ENTRIES * 12 * MAX_DIV + 2000;

  // Register map
  localparam logic [7:0] A_CTRL        = 8'h00;
  localparam logic [7:0] A_STATUS      = 8'h04;
  localparam logic [7:0] A_WDATA       = 8'h08;
  localparam logic [7:0] A_RDATA       = 8'h0C;
  localparam logic [7:0] A_INTR_STATE  = 8'h10;
  localparam logic [7:0] A_INTR_ENABLE = 8'h14;

  // Interrupt bits
  localparam int I_TX_EMPTY = 0;
  localparam int I_OVERFLOW = 1;
  localparam int I_FRAME    = 2;
  localparam int I_PARITY   = 3;

  // Inject error kinds
  localparam int KIND_NONE     = 0;
  localparam int KIND_BAD_PAR  = 1;
  localparam int KIND_BAD_STOP = 2;

  typedef struct {
    int unsigned div;
    logic        par;
    logic [7:0]  data;
    int          kind;
  } stim_t;

  logic        clk;
  logic        rst;
  logic        req;
  logic        we;
  logic [7:0]  addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        tx;
  logic        tx_en;
  logic        intr_txe;
  logic        intr_ovf;
  logic        intr_frame;
  logic        intr_par;
  logic        inject;
  logic        inj_line;
  logic        rx_line;
  logic [3:0]  intr_vec;

  stim_t       stim [NUM_ENTRIES];
  logic [7:0]  sent [FIFO_DEPTH + 1];
  int          err_count;
  int          cycle_count;

  // Loopback unless the serial injector owns the line
  assign rx_line  = inject ? inj_line : tx;
  assign intr_vec = {intr_par, intr_frame, intr_ovf, intr_txe};

  uart #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk_i                (clk),
    .rst_i                (rst),
    .req_i                (req),
    .we_i                 (we),
    .addr_i               (addr),
    .wdata_i              (wdata),
    .rdata_o              (rdata),
    .rx_i                 (rx_line),
    .tx_o                 (tx),
    .tx_en_o              (tx_en),
    .intr_tx_empty_o      (intr_txe),
    .intr_rx_overflow_o   (intr_ovf),
    .intr_rx_frame_err_o  (intr_frame),
    .intr_rx_parity_err_o (intr_par)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog on total run length
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run exceeded %0d cycles waiting on the DUT", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp) begin
      err_count++;
      $display("** Error: %s actual 0x%08h expected 0x%08h", name, act, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic bus_write(input logic [7:0] a, input logic [31:0] d);
    @(negedge clk);
    req   = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge clk);
    req = 1'b0;
    we  = 1'b0;
  endtask

  // Read data is valid one cycle after the request
  task automatic bus_read(input logic [7:0] a, output logic [31:0] d);
    @(negedge clk);
    req  = 1'b1;
    we   = 1'b0;
    addr = a;
    @(negedge clk);
    req = 1'b0;
    d   = rdata;
  endtask

  task automatic hold_line(input logic b, input int unsigned n);
    @(negedge clk);
    inj_line = b;
    repeat (n - 1) @(negedge clk);
  endtask

  // Start, data LSB first, optional even parity, stop, then idle
  task automatic send_frame(input int unsigned div, input logic par,
                            input logic [7:0] data, input int kind);
    logic [10:0] bits;
    int          nbits;
    bits      = '1;
    bits[0]   = 1'b0;
    bits[8:1] = data;
    if (par) begin
      bits[9]  = (^data) ^ (kind == KIND_BAD_PAR);
      bits[10] = (kind != KIND_BAD_STOP);
      nbits    = 11;
    end else begin
      bits[9] = (kind != KIND_BAD_STOP);
      nbits   = 10;
    end
    for (int i = 0; i < nbits; i++) begin
      hold_line(bits[i], div);
    end
    hold_line(1'b1, 2 * div);
  endtask

  function automatic logic [31:0] ctrl_word(input int unsigned div, input logic par,
                                            input logic tx_on, input logic rx_on);
    logic [31:0] w;
    w        = '0;
    w[31:16] = div[15:0];
    w[2]     = par;
    w[1]     = rx_on;
    w[0]     = tx_on;
    return w;
  endfunction

  // STATUS layout from tx full up to tx idle
  function automatic logic [31:0] status_word(input logic txf, input logic txe,
                                              input logic rxf, input logic rxe,
                                              input logic txi);
    return {27'd0, txi, rxe, rxf, txe, txf};
  endfunction

  // RDATA layout with parity error at 9 and frame error at 8
  function automatic logic [31:0] rdata_word(input logic [7:0] data, input int kind);
    return {22'd0, kind == KIND_BAD_PAR, kind == KIND_BAD_STOP, data};
  endfunction

  task automatic wait_rx_ready();
    logic [31:0] st;
    st = 32'h8;
    while (st[3]) begin
      bus_read(A_STATUS, st);
    end
  endtask

  task automatic wait_rx_full();
    logic [31:0] st;
    st = '0;
    while (!st[2]) begin
      bus_read(A_STATUS, st);
    end
  endtask

  task automatic wait_tx_done();
    logic [31:0] st;
    st = '0;
    while (!(st[1] && st[4])) begin
      bus_read(A_STATUS, st);
    end
  endtask

  // Masked while disabled, visible once enabled, gone after write-1 clear
  task automatic check_intr(input int idx, input string name);
    check_value(name, 32'(intr_vec[idx]), 32'd0);
    bus_write(A_INTR_ENABLE, 32'd1 << idx);
    wait_cycles(1);
    check_value(name, 32'(intr_vec[idx]), 32'd1);
    bus_write(A_INTR_STATE, 32'd1 << idx);
    wait_cycles(1);
    check_value(name, 32'(intr_vec[idx]), 32'd0);
    bus_write(A_INTR_ENABLE, 32'd0);
  endtask

  // Two bytes at each divisor and parity setting, then error frames
  task automatic build_stim();
    logic [7:0] filler;
    filler = 8'($urandom);
    for (int i = 0; i < 8; i++) begin
      stim[i].div  = i[1] ? 7 : 4;
      stim[i].par  = i[0];
      stim[i].data = (i < 4) ? 8'hD3 : filler;
      stim[i].kind = KIND_NONE;
    end
    for (int i = 8; i < NUM_ENTRIES; i++) begin
      stim[i].div  = i[0] ? 7 : 4;
      stim[i].par  = (i < 10);
      stim[i].data = 8'($urandom);
      stim[i].kind = (i < 10) ? KIND_BAD_PAR : KIND_BAD_STOP;
    end
  endtask

  initial begin
    logic [31:0] rd;
    rst       = 1'b1;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    inject    = 1'b0;
    inj_line  = 1'b1;
    err_count = 0;
    void'($urandom(32'hb64f_7590));
    build_stim();
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // Reset state
    bus_read(A_STATUS, rd);
    check_value("status", rd, status_word(1'b0, 1'b1, 1'b0, 1'b1, 1'b1));
    check_value("tx_o", 32'(tx), 32'd1);
    check_value("tx_en_o", 32'(tx_en), 32'd1);
    check_value("intr", 32'(intr_vec), 32'd0);
    bus_read(A_RDATA, rd);
    check_value("rdata", rd, 32'd0);

    // Table of loopback and injected frames
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      bus_write(A_CTRL, ctrl_word(stim[i].div, stim[i].par, 1'b1, 1'b1));
      if (stim[i].kind == KIND_NONE) begin
        inject = 1'b0;
        bus_write(A_WDATA, {24'd0, stim[i].data});
      end else begin
        inject = 1'b1;
        send_frame(stim[i].div, stim[i].par, stim[i].data, stim[i].kind);
      end
      wait_rx_ready();
      bus_read(A_RDATA, rd);
      check_value("rdata", rd, rdata_word(stim[i].data, stim[i].kind));
      if (stim[i].kind == KIND_BAD_PAR) begin
        check_intr(I_PARITY, "intr_rx_parity_err_o");
      end else if (stim[i].kind == KIND_BAD_STOP) begin
        check_intr(I_FRAME, "intr_rx_frame_err_o");
      end
      inject = 1'b0;
    end

    // One frame more than the receive FIFO holds
    bus_write(A_CTRL, ctrl_word(4, 1'b0, 1'b1, 1'b1));
    bus_write(A_INTR_ENABLE, 32'd1 << I_OVERFLOW);
    inject = 1'b1;
    for (int k = 0; k <= FIFO_DEPTH; k++) begin
      sent[k] = 8'($urandom);
      send_frame(4, 1'b0, sent[k], KIND_NONE);
    end
    inject = 1'b0;
    wait_cycles(2);
    check_value("intr_rx_overflow_o", 32'(intr_ovf), 32'd1);
    bus_read(A_STATUS, rd);
    check_value("status", rd, status_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      bus_read(A_RDATA, rd);
      check_value("rdata", rd, rdata_word(sent[k], KIND_NONE));
    end
    bus_read(A_RDATA, rd);
    check_value("rdata", rd, 32'd0);

    // Transmit FIFO overfilled while transmission is off
    bus_write(A_INTR_STATE, 32'hF);
    bus_write(A_INTR_ENABLE, 32'd1 << I_TX_EMPTY);
    bus_write(A_CTRL, ctrl_word(4, 1'b0, 1'b0, 1'b1));
    for (int k = 0; k <= FIFO_DEPTH; k++) begin
      sent[k] = 8'($urandom);
      bus_write(A_WDATA, {24'd0, sent[k]});
    end
    bus_read(A_STATUS, rd);
    check_value("status", rd, status_word(1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
    check_value("intr_tx_empty_o", 32'(intr_txe), 32'd0);
    bus_write(A_CTRL, ctrl_word(4, 1'b0, 1'b1, 1'b1));
    wait_tx_done();
    // Last frame lands after the transmitter goes idle
    wait_rx_full();
    bus_read(A_STATUS, rd);
    check_value("status", rd, status_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      bus_read(A_RDATA, rd);
      check_value("rdata", rd, rdata_word(sent[k], KIND_NONE));
    end
    bus_read(A_RDATA, rd);
    check_value("rdata", rd, 32'd0);
    check_value("intr_tx_empty_o", 32'(intr_txe), 32'd1);
    // No overflow so the dropped byte never went out
    bus_read(A_INTR_STATE, rd);
    check_value("intr_state", rd, 32'd1 << I_TX_EMPTY);

    $display("Checks finished after %0d cycles with %0d errors", cycle_count, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* uart_sys.f */
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart.sv
test/tb_uart.sv
